/* logic/edge_pe_pkg.sv */
package edge_pe_pkg;

    localparam int NODE_W = 7;   // 128 nodes
    typedef logic [NODE_W-1:0] node_id_t;

    localparam int NUM_PE   = 4;
    localparam int PE_TAG_W = $clog2(NUM_PE);

    localparam int FV_LANES  = 2;
    localparam int FV_LANE_W = 8;
    typedef logic [FV_LANE_W-1:0] fv_lane_t;
    localparam int FV_BEAT_W = FV_LANES * FV_LANE_W;

    localparam int IDS_PER_BEAT = 2;

    typedef enum logic {
        kind_nbr_ids = 1'b0,
        kind_feature = 1'b1
    } req_kind_t;

    typedef enum logic [2:0] {
        st_idle,
        st_req_ids,
        st_wait_ids,
        st_req_fv,
        st_wait_fv,
        st_finish
    } ctrl_state_t;

endpackage

/* logic/nbr_if.sv */
`timescale 1ns/1ns

interface nbr_if import edge_pe_pkg::*; #(
    parameter int max_degree = 16
) ();
    localparam int cnt_w = $clog2(max_degree + 1);
    localparam int idx_w = $clog2(max_degree);

    logic             collect;    // high while the id stream is expected
    logic             list_done;
    logic [cnt_w-1:0] count;
    logic [idx_w-1:0] rd_index;
    node_id_t         rd_id;

    modport ctrl (output collect, rd_index, input list_done, count, rd_id);
    modport list (input collect, rd_index, output list_done, count, rd_id);

endinterface

/* logic/bank_if.sv */
`timescale 1ns/1ns

interface bank_if import edge_pe_pkg::*; ();

    logic     forward;   // feature vector expected
    node_id_t target;
    logic     fv_last;
    logic     finish;    // one cycle, becomes done_aggr

    modport ctrl (output forward, target, finish, input fv_last);
    modport stream (input forward, target, finish, output fv_last);

endinterface

/* logic/neighbor_list.sv */
`timescale 1ns/1ns

module neighbor_list import edge_pe_pkg::*; #(
    parameter int max_degree = 16
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 nbr_sos,
    input  logic                                 nbr_eos,
    input  logic [$clog2(max_degree + 1)-1:0]    nbr_count,
    input  node_id_t [IDS_PER_BEAT-1:0]          nbr_ids,
    nbr_if.list                                  nbr
);
    localparam int cnt_w = $clog2(max_degree + 1);
    localparam int idx_w = $clog2(max_degree);

    node_id_t         ids [max_degree];
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] wr_base;
    logic [cnt_w-1:0] count_q;
    logic             accept;

    assign accept  = nbr.collect;
    assign wr_base = nbr_sos ? '0 : wr_idx;   // sos always restarts the list

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_idx  <= '0;
            count_q <= '0;
        end else if (accept) begin
            wr_idx <= nbr_eos ? '0 : wr_base + idx_w'(IDS_PER_BEAT);
            if (nbr_sos) begin
                count_q <= nbr_count;
            end
        end
    end

    // lower half of the beat goes to the lower index
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < IDS_PER_BEAT; i++) begin
                ids[wr_base + idx_w'(i)] <= nbr_ids[i];
            end
        end
    end

    assign nbr.count     = count_q;
    assign nbr.rd_id     = ids[nbr.rd_index];
    assign nbr.list_done = accept && nbr_eos;

endmodule

/* logic/bank_stream.sv */
`timescale 1ns/1ns

module bank_stream import edge_pe_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fv_sos,
    input  logic                 fv_eos,
    input  logic [FV_BEAT_W-1:0] fv_data,
    output logic                 bank_sos,
    output logic                 bank_eos,
    output fv_lane_t             bank_lane0,
    output fv_lane_t             bank_lane1,
    output node_id_t             bank_node,
    output logic                 done_aggr,
    bank_if.stream               bank
);
    logic accept;
    logic open;   // inside an accepted stream

    assign accept       = bank.forward && (fv_sos || open);
    assign bank.fv_last = accept && fv_eos;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            open      <= 1'b0;
            bank_sos  <= 1'b0;
            bank_eos  <= 1'b0;
            done_aggr <= 1'b0;
        end else begin
            bank_sos  <= accept && fv_sos;
            bank_eos  <= accept && fv_eos;
            done_aggr <= bank.finish;
            if (accept) begin
                open <= !fv_eos;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bank_lane0 <= fv_data[FV_LANE_W-1:0];
            bank_lane1 <= fv_data[FV_BEAT_W-1:FV_LANE_W];
        end
        if (accept || bank.finish) begin
            bank_node <= bank.target;   // target also tags done_aggr
        end
    end

endmodule

/* logic/edge_pe_ctrl.sv */
`timescale 1ns/1ns

module edge_pe_ctrl import edge_pe_pkg::*; #(
    parameter int max_degree = 16,
    parameter int pe_tag     = 0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                task_valid,
    input  node_id_t            task_node,
    input  logic                arb_grant,
    output logic                arb_req,
    output logic [PE_TAG_W-1:0] arb_tag,
    output req_kind_t           arb_kind,
    output node_id_t            arb_node,
    output logic                idle_flag,
    nbr_if.ctrl                 nbr,
    bank_if.ctrl                bank
);
    localparam int cnt_w = $clog2(max_degree + 1);
    localparam int idx_w = $clog2(max_degree);

    ctrl_state_t      state;
    ctrl_state_t      state_next;
    node_id_t         target;
    logic [idx_w-1:0] fv_ptr;
    logic             last_nbr;

    assign last_nbr = (cnt_w'(fv_ptr) + 1'b1) == nbr.count;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (task_valid) state_next = st_req_ids;
            end
            st_req_ids: begin
                if (arb_grant) state_next = st_wait_ids;
            end
            st_wait_ids: begin
                if (nbr.list_done) state_next = st_req_fv;
            end
            st_req_fv: begin
                if (arb_grant) state_next = st_wait_fv;
            end
            st_wait_fv: begin
                if (bank.fv_last) begin
                    state_next = last_nbr ? st_finish : st_req_fv;
                end
            end
            st_finish: state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state  <= st_idle;
            fv_ptr <= '0;
        end else begin
            state <= state_next;
            if (bank.fv_last) begin
                fv_ptr <= last_nbr ? '0 : fv_ptr + 1'b1;   // wraps for the next task
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && task_valid) begin
            target <= task_node;
        end
    end

    // request is a level held until the grant
    assign arb_req  = (state == st_req_ids) || (state == st_req_fv);
    assign arb_tag  = PE_TAG_W'(pe_tag);
    assign arb_kind = (state == st_req_fv) ? kind_feature : kind_nbr_ids;
    assign arb_node = (state == st_req_fv) ? nbr.rd_id : target;

    assign idle_flag    = state == st_idle;
    assign nbr.collect  = state == st_wait_ids;
    assign nbr.rd_index = fv_ptr;
    assign bank.forward = state == st_wait_fv;
    assign bank.target  = target;
    assign bank.finish  = state == st_finish;

endmodule

/* logic/edge_pe.sv */
`timescale 1ns/1ns

module edge_pe import edge_pe_pkg::*; #(
    parameter int max_degree = 16,
    parameter int pe_tag     = 0
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              task_valid,
    input  node_id_t                          task_node,
    input  logic                              arb_grant,
    input  logic                              nbr_sos,
    input  logic                              nbr_eos,
    input  logic [$clog2(max_degree + 1)-1:0] nbr_count,
    input  node_id_t [IDS_PER_BEAT-1:0]       nbr_ids,
    input  logic                              fv_sos,
    input  logic                              fv_eos,
    input  logic [FV_BEAT_W-1:0]              fv_data,
    output logic                              arb_req,
    output logic [PE_TAG_W-1:0]               arb_tag,
    output req_kind_t                         arb_kind,
    output node_id_t                          arb_node,
    output logic                              bank_sos,
    output logic                              bank_eos,
    output fv_lane_t                          bank_lane0,
    output fv_lane_t                          bank_lane1,
    output node_id_t                          bank_node,
    output logic                              done_aggr,
    output logic                              idle_flag
);
    nbr_if #(.max_degree(max_degree)) nbr_bus ();
    bank_if bank_bus ();

    edge_pe_ctrl #(
        .max_degree (max_degree),
        .pe_tag     (pe_tag)
    ) i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .task_valid (task_valid),
        .task_node  (task_node),
        .arb_grant  (arb_grant),
        .arb_req    (arb_req),
        .arb_tag    (arb_tag),
        .arb_kind   (arb_kind),
        .arb_node   (arb_node),
        .idle_flag  (idle_flag),
        .nbr        (nbr_bus.ctrl),
        .bank       (bank_bus.ctrl)
    );

    neighbor_list #(.max_degree(max_degree)) i_list (
        .clk       (clk),
        .reset     (reset),
        .nbr_sos   (nbr_sos),
        .nbr_eos   (nbr_eos),
        .nbr_count (nbr_count),
        .nbr_ids   (nbr_ids),
        .nbr       (nbr_bus.list)
    );

    bank_stream i_stream (
        .clk        (clk),
        .reset      (reset),
        .fv_sos     (fv_sos),
        .fv_eos     (fv_eos),
        .fv_data    (fv_data),
        .bank_sos   (bank_sos),
        .bank_eos   (bank_eos),
        .bank_lane0 (bank_lane0),
        .bank_lane1 (bank_lane1),
        .bank_node  (bank_node),
        .done_aggr  (done_aggr),
        .bank       (bank_bus.stream)
    );

endmodule

/* tests/tb_drive.svh */
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic clear_inputs();
    task_valid = 1'b0;
    task_node  = '0;
    arb_grant  = 1'b0;
    nbr_sos    = 1'b0;
    nbr_eos    = 1'b0;
    nbr_count  = '0;
    nbr_ids    = '0;
    fv_sos     = 1'b0;
    fv_eos     = 1'b0;
    fv_data    = '0;
    fv_live    = 1'b0;
endtask

// request is pending here, so stray beats must be ignored
task automatic give_grant();
    int d;
    d = rand_range(0, 5);
    repeat (d) begin
        if (next_rand() % 2 == 1) begin
            nbr_sos = 1'b1;
            nbr_eos = 1'b1;
            nbr_ids = node_id_t'(next_rand());
            fv_sos  = 1'b1;
            fv_eos  = 1'b1;
            fv_data = FV_BEAT_W'(next_rand());
        end
        next_cycle();
        clear_inputs();
    end
    arb_grant = 1'b1;
    next_cycle();
    arb_grant = 1'b0;
endtask

task automatic send_ids(int n);
    int beats;
    node_id_t id;
    beats = (n + 1) / 2;
    repeat (rand_range(0, 3)) next_cycle();
    for (int b = 0; b < beats; b++) begin
        nbr_sos   = b == 0;
        nbr_eos   = b == beats - 1;
        nbr_count = CNT_W'(n);
        for (int i = 0; i < IDS_PER_BEAT; i++) begin
            id = node_id_t'(next_rand());
            nbr_ids[i] = id;
            if (2 * b + i < n) exp_req.push_back('{kind: kind_feature, node: id});
        end
        next_cycle();
    end
    clear_inputs();
endtask

task automatic send_fv();
    int len;
    beat_t b;
    len = rand_range(1, 4);
    repeat (rand_range(0, 3)) next_cycle();
    for (int k = 0; k < len; k++) begin
        b.sos  = k == 0;
        b.eos  = k == len - 1;
        b.data = FV_BEAT_W'(next_rand());
        fv_sos  = b.sos;
        fv_eos  = b.eos;
        fv_data = b.data;
        fv_live = 1'b1;
        exp_beat.push_back(b);
        next_cycle();
    end
    clear_inputs();
endtask

task automatic run_task(node_id_t node, int n);
    while (!idle_flag) next_cycle();
    target_q   = node;
    nbr_left   = n;
    task_valid = 1'b1;
    task_node  = node;
    exp_req.push_back('{kind: kind_nbr_ids, node: node});
    next_cycle();
    task_valid = 1'b0;
    give_grant();
    send_ids(n);
    for (int i = 0; i < n; i++) begin
        give_grant();
        send_fv();
    end
    while (!done_aggr) next_cycle();
    if (exp_req.size() != 0 || exp_beat.size() != 0) begin
        proto_errs++;
        $display("task %0d finished with %0d requests and %0d beats still expected",
                 node, exp_req.size(), exp_beat.size());
    end
endtask

/* tests/edge_pe_tb.sv */
`timescale 1ns/1ns

module edge_pe_tb import edge_pe_pkg::*;;
    localparam int MAX_DEG = 16;
    localparam int CNT_W   = $clog2(MAX_DEG + 1);
    localparam int LIMIT   = 25 * 16 * 20 + 500;

    typedef struct packed {
        req_kind_t kind;
        node_id_t  node;
    } req_t;

    typedef struct packed {
        logic                 sos;
        logic                 eos;
        logic [FV_BEAT_W-1:0] data;
    } beat_t;

    logic clk = 1'b0;
    logic reset;
    logic task_valid;
    node_id_t task_node;
    logic arb_grant;
    logic nbr_sos;
    logic nbr_eos;
    logic [CNT_W-1:0] nbr_count;
    node_id_t [IDS_PER_BEAT-1:0] nbr_ids;
    logic fv_sos;
    logic fv_eos;
    logic [FV_BEAT_W-1:0] fv_data;
    logic arb_req;
    logic [PE_TAG_W-1:0] arb_tag;
    req_kind_t arb_kind;
    node_id_t arb_node;
    logic bank_sos;
    logic bank_eos;
    fv_lane_t bank_lane0;
    fv_lane_t bank_lane1;
    node_id_t bank_node;
    logic done_aggr;
    logic idle_flag;

    logic [31:0] rng = 32'h74a2;
    int value_errs = 0;
    int proto_errs = 0;
    int cycles = 0;
    node_id_t target_q;    // node of the task in flight
    node_id_t fin_node_q;  // target of the task that just finished
    int nbr_left = 0;      // feature vectors still to reach the bank
    logic fv_live;         // a real beat is on the feature inputs
    logic live_q;
    logic last_eos_q;
    logic exp_idle;
    req_t exp_req[$];
    beat_t exp_beat[$];

    always #2 clk = ~clk;

    edge_pe #(.max_degree(MAX_DEG), .pe_tag(2)) i_edge_pe (.*);

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic int rand_range(int lo, int hi);
        return lo + int'(next_rand() % 32'(hi - lo + 1));
    endfunction

    `include "tb_drive.svh"

    a_id_req: assert property (@(posedge clk) disable iff (!reset)
        (idle_flag && task_valid) |=> (arb_req && arb_kind == kind_nbr_ids
            && arb_node == target_q))
        else begin
            proto_errs++;
            $display("id request missing or wrong one cycle after task at %0t", $time);
        end

    a_hold: assert property (@(posedge clk) disable iff (!reset)
        (arb_req && !arb_grant) |=> arb_req)
        else begin
            proto_errs++;
            $display("arbiter request dropped before its grant at %0t", $time);
        end

    a_drop: assert property (@(posedge clk) disable iff (!reset)
        (arb_req && arb_grant) |=> !arb_req)
        else begin
            proto_errs++;
            $display("arbiter request still high after its grant at %0t", $time);
        end

    a_tag: assert property (@(posedge clk) disable iff (!reset)
        arb_req |-> arb_tag == PE_TAG_W'(2))
        else begin
            value_errs++;
            $display("error %0t arb_tag expected 2 got %0d", $time, arb_tag);
        end

    a_done_once: assert property (@(posedge clk) disable iff (!reset)
        done_aggr |=> !done_aggr)
        else begin
            proto_errs++;
            $display("done_aggr high for more than one cycle at %0t", $time);
        end

    a_done_node: assert property (@(posedge clk) disable iff (!reset)
        done_aggr |-> (idle_flag && bank_node == fin_node_q))
        else begin
            value_errs++;
            $display("error %0t bank_node/idle_flag at done expected %0d/1 got %0d/%b",
                     $time, fin_node_q, bank_node, idle_flag);
        end

    always @(posedge clk) begin : monitor
        req_t r;
        beat_t b;
        logic fin;
        fin = 1'b0;
        if (!reset) begin
            live_q     <= 1'b0;
            last_eos_q <= 1'b0;
            exp_idle   <= 1'b1;
        end else begin
            if (arb_req && arb_grant) begin
                if (exp_req.size() == 0) begin
                    proto_errs++;
                    $display("grant taken for a request that was not expected at %0t", $time);
                end else begin
                    r = exp_req.pop_front();
                    assert (arb_kind == r.kind) else begin
                        value_errs++;
                        $display("error %0t arb_kind expected %0d got %0d",
                                 $time, r.kind, arb_kind);
                    end
                    assert (arb_node == r.node) else begin
                        value_errs++;
                        $display("error %0t arb_node expected %0d got %0d",
                                 $time, r.node, arb_node);
                    end
                end
            end
            if (live_q && exp_beat.size() != 0) begin
                b = exp_beat.pop_front();
                assert (bank_sos == b.sos && bank_eos == b.eos) else begin
                    value_errs++;
                    $display("error %0t bank_sos/bank_eos expected %b%b got %b%b",
                             $time, b.sos, b.eos, bank_sos, bank_eos);
                end
                assert (bank_lane0 == b.data[7:0] && bank_lane1 == b.data[15:8]) else begin
                    value_errs++;
                    $display("error %0t bank_lane1/0 expected %h got %h%h",
                             $time, b.data, bank_lane1, bank_lane0);
                end
                assert (bank_node == target_q) else begin
                    value_errs++;
                    $display("error %0t bank_node expected %0d got %0d",
                             $time, target_q, bank_node);
                end
                if (b.eos) begin
                    fin = nbr_left == 1;
                    nbr_left--;
                end
            end else begin
                assert (!bank_sos && !bank_eos) else begin
                    proto_errs++;
                    $display("stray feature beat reached the bank at %0t", $time);
                end
            end
            assert (done_aggr == last_eos_q) else begin
                value_errs++;
                $display("error %0t done_aggr expected %b got %b", $time, last_eos_q, done_aggr);
            end
            assert (idle_flag == exp_idle) else begin
                value_errs++;
                $display("error %0t idle_flag expected %b got %b", $time, exp_idle, idle_flag);
            end
            // busy from the accepted task until the done cycle
            if (exp_idle && task_valid) begin
                exp_idle <= 1'b0;
            end else if (fin) begin
                exp_idle <= 1'b1;
            end
            if (fin) begin
                fin_node_q <= target_q;
            end
            live_q     <= fv_live;
            last_eos_q <= fin;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("errors: value %0d, protocol %0d", value_errs, proto_errs + 1);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        reset = 1'b0;
        clear_inputs();
        repeat (3) @(posedge clk);
        #1 reset = 1'b1;
        assert (!arb_req && !bank_sos && !bank_eos && !done_aggr && idle_flag) else begin
            proto_errs++;
            $display("outputs not at their reset values after reset");
        end
        next_cycle();
        // directed counts, the last one a single-beat id stream
        run_task(node_id_t'(next_rand()), 1);
        run_task(node_id_t'(next_rand()), 2);
        run_task(node_id_t'(next_rand()), 3);
        run_task(node_id_t'(next_rand()), 16);
        run_task(node_id_t'(next_rand()), 2);
        repeat (20) run_task(node_id_t'(next_rand()), rand_range(1, 16));
        repeat (3) next_cycle();
        $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+tests
logic/edge_pe_pkg.sv
logic/nbr_if.sv
logic/bank_if.sv
logic/neighbor_list.sv
logic/bank_stream.sv
logic/edge_pe_ctrl.sv
logic/edge_pe.sv
tests/edge_pe_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0 -Mdir obj_dir
TOP       = edge_pe_tb
FILELIST  = sources.f
LOG       = sim.log

BIN  = obj_dir/V$(TOP)
SRCS = $(wildcard logic/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
